// File: Makefile
# Verilator build and run of the lane testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_lane_unit \
		-f compile.f -Mdir obj_dir -o sim_lane

run: compile
	./obj_dir/sim_lane > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: compile.f
+incdir+.
lane_pkg.sv
lane_issue_decode.sv
lane_command_queue.sv
lane_register_bank.sv
lane_execute.sv
lane_unit.sv
lane_unit_sva.sv
lane_checker.sv
tb_lane_unit.sv

// File: lane_checker.sv
/*
 Scoreboard for the lane: model registers plus a queue of expected commits.
 Expected values are computed when a command is sent, in command order.
 end_of_test asks for a drain check against the sender's credit count.
*/
`default_nettype none

`include "lane_config.svh"

module lane_checker (
	input wire logic                      clock,
	input wire logic                      reset,
	input wire logic                      cmd_valid,
	input wire logic [`LANE_OP_WIDTH-1:0] cmd_op,
	input wire lane_pkg::reg_index_t      cmd_dst,
	input wire lane_pkg::reg_index_t      cmd_src1,
	input wire lane_pkg::reg_index_t      cmd_src2,
	input wire lane_pkg::lane_data_t      cmd_scalar,
	input wire logic                      credit_return,
	input wire logic                      commit_valid,
	input wire lane_pkg::reg_index_t      commit_dst,
	input wire lane_pkg::lane_data_t      commit_data,
	input wire logic                      end_of_test,
	input int                             sender_credits,
	output int                            error_count,
	output int                            commit_count,
	output int                            pending
);

	timeunit 1ns;
	timeprecision 1ps;

	lane_pkg::lane_data_t model_regs [`LANE_NUM_REGS];
	lane_pkg::reg_index_t exp_dst_q [$];
	lane_pkg::lane_data_t exp_data_q [$];
	int                   cmd_total;
	int                   credit_total;

	// Result of one command as the instruction set defines it
	function automatic lane_pkg::lane_data_t reference_result(
		input logic [`LANE_OP_WIDTH-1:0] op,
		input lane_pkg::lane_data_t a,
		input lane_pkg::lane_data_t b,
		input lane_pkg::lane_data_t scalar
	);
		case (op)
			lane_pkg::OP_ADD: return a + b;
			lane_pkg::OP_SUB: return a - b;
			lane_pkg::OP_AND: return a & b;
			lane_pkg::OP_OR:  return a | b;
			lane_pkg::OP_XOR: return a ^ b;
			lane_pkg::OP_SLL: return a << b[4:0];
			lane_pkg::OP_SRL: return a >> b[4:0];
			default:          return scalar;
		endcase
	endfunction

	task automatic record_command();
		lane_pkg::lane_data_t result;
		result = reference_result(cmd_op, model_regs[cmd_src1], model_regs[cmd_src2],
			cmd_scalar);
		model_regs[cmd_dst] = result;
		exp_dst_q.push_back(cmd_dst);
		exp_data_q.push_back(result);
		cmd_total++;
	endtask

	task automatic check_commit();
		lane_pkg::reg_index_t want_dst;
		lane_pkg::lane_data_t want_data;
		commit_count++;
		if (exp_data_q.size() == 0) begin
			$display("Error at %0t: commit seen with no command outstanding", $time);
			error_count++;
		end else begin
			want_dst  = exp_dst_q.pop_front();
			want_data = exp_data_q.pop_front();
			if (commit_dst !== want_dst) begin
				$display("[ERROR] %0t commit_dst expected %0d actual %0d",
					$time, want_dst, commit_dst);
				error_count++;
			end
			if (commit_data !== want_data) begin
				$display("[ERROR] %0t commit_data expected %08h actual %08h",
					$time, want_data, commit_data);
				error_count++;
			end
		end
	endtask

	// Every command drained: one credit and one commit each
	task automatic check_drain();
		if (commit_count != cmd_total) begin
			$display("Error at %0t: %0d commands sent but %0d commits seen",
				$time, cmd_total, commit_count);
			error_count++;
		end
		if (credit_total != cmd_total) begin
			$display("Error at %0t: %0d commands sent but %0d credits returned",
				$time, cmd_total, credit_total);
			error_count++;
		end
		if (sender_credits != `LANE_QUEUE_DEPTH) begin
			$display("Error at %0t: sender holds %0d credits after drain, not %0d",
				$time, sender_credits, `LANE_QUEUE_DEPTH);
			error_count++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Monitor
	always @(posedge clock) begin
		if (reset) begin
			foreach (model_regs[i]) begin
				model_regs[i] = '0;
			end
			exp_dst_q.delete();
			exp_data_q.delete();
			cmd_total    = 0;
			credit_total = 0;
			commit_count = 0;
			error_count  = 0;
		end else begin
			// Idle lane after reset must stay silent
			if ((cmd_total == 0) && (commit_valid || credit_return)) begin
				$display("Error at %0t: commit or credit seen before any command", $time);
				error_count++;
			end
			if (credit_return) begin
				credit_total++;
			end
			if (commit_valid) begin
				check_commit();
			end
			if (cmd_valid) begin
				record_command();
			end
			if (end_of_test) begin
				check_drain();
			end
		end
		pending = exp_data_q.size();
	end

endmodule

`default_nettype wire

// File: lane_command_queue.sv
/*
 Circular FIFO of decoded commands, LANE_QUEUE_DEPTH entries.
 No full flag: the sender's credits keep pushes off a full queue.
 Each released entry returns one credit in the same cycle.
*/
`default_nettype none

`include "lane_config.svh"

module lane_command_queue (
	input  wire logic                  clock,
	input  wire logic                  reset,
	input  wire logic                  dec_valid,
	input  wire lane_pkg::lane_op_e    dec_op,
	input  wire lane_pkg::read_plan_e  dec_plan,
	input  wire lane_pkg::reg_index_t  dec_dst,
	input  wire lane_pkg::reg_index_t  dec_src1,
	input  wire lane_pkg::reg_index_t  dec_src2,
	input  wire lane_pkg::lane_data_t  dec_scalar,
	input  wire logic                  q_pop,
	output logic                       q_valid,
	output lane_pkg::lane_op_e         q_op,
	output lane_pkg::read_plan_e       q_plan,
	output lane_pkg::reg_index_t       q_dst,
	output lane_pkg::reg_index_t       q_src1,
	output lane_pkg::reg_index_t       q_src2,
	output lane_pkg::lane_data_t       q_scalar,
	output logic                       credit_return
);

	localparam int DEPTH = `LANE_QUEUE_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

	lane_pkg::lane_op_e   op_mem     [DEPTH];
	lane_pkg::read_plan_e plan_mem   [DEPTH];
	lane_pkg::reg_index_t dst_mem    [DEPTH];
	lane_pkg::reg_index_t src1_mem   [DEPTH];
	lane_pkg::reg_index_t src2_mem   [DEPTH];
	lane_pkg::lane_data_t scalar_mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             pop;

	assign q_valid       = (count != '0);
	assign pop           = q_pop && q_valid;
	assign credit_return = pop;

	////////////////////////////////////////////////////////////
	// Pointers and occupancy
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (dec_valid) begin
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			end
			case ({dec_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Entry storage
	always_ff @(posedge clock) begin
		if (dec_valid) begin
			op_mem[wr_ptr]     <= dec_op;
			plan_mem[wr_ptr]   <= dec_plan;
			dst_mem[wr_ptr]    <= dec_dst;
			src1_mem[wr_ptr]   <= dec_src1;
			src2_mem[wr_ptr]   <= dec_src2;
			scalar_mem[wr_ptr] <= dec_scalar;
		end
	end

	// Head entry
	assign q_op     = op_mem[rd_ptr];
	assign q_plan   = plan_mem[rd_ptr];
	assign q_dst    = dst_mem[rd_ptr];
	assign q_src1   = src1_mem[rd_ptr];
	assign q_src2   = src2_mem[rd_ptr];
	assign q_scalar = scalar_mem[rd_ptr];

endmodule

`default_nettype wire

// File: lane_config.svh
/*
 Widths and depths shared by the lane RTL and its testbench.
 LANE_QUEUE_DEPTH is also the sender's initial credit count.
 LANE_NUM_REGS must be even and a power of two.
*/
`ifndef LANE_CONFIG_SVH
`define LANE_CONFIG_SVH

// Data path
`define LANE_DATA_WIDTH 32
`define LANE_OP_WIDTH 3

// Register file, split into odd and even banks
`define LANE_NUM_REGS 32
`define LANE_REG_INDEX_WIDTH 5
`define LANE_ROW_WIDTH 4

// Command queue
`define LANE_QUEUE_DEPTH 4

`endif

// File: lane_execute.sv
/*
 Pops one command at a time and runs it to commit.
 Commit follows the pop by 1, 2 or 3 cycles for PLAN_NONE, PARALLEL and SERIAL.
 Write-back is done in the commit cycle; the next pop may share that cycle.
*/
`default_nettype none

`include "lane_config.svh"

module lane_execute (
	input  wire logic                         clock,
	input  wire logic                         reset,
	input  wire logic                         q_valid,
	input  wire lane_pkg::lane_op_e           q_op,
	input  wire lane_pkg::read_plan_e         q_plan,
	input  wire lane_pkg::reg_index_t         q_dst,
	input  wire lane_pkg::reg_index_t         q_src1,
	input  wire lane_pkg::reg_index_t         q_src2,
	input  wire lane_pkg::lane_data_t         q_scalar,
	output logic                              q_pop,
	output logic                              odd_rd_en,
	output lane_pkg::bank_row_t               odd_rd_row,
	output logic                              even_rd_en,
	output lane_pkg::bank_row_t               even_rd_row,
	input  wire lane_pkg::lane_data_t         odd_rd_data,
	input  wire lane_pkg::lane_data_t         even_rd_data,
	output logic                              odd_wr_en,
	output logic                              even_wr_en,
	output lane_pkg::bank_row_t               wr_row,
	output lane_pkg::lane_data_t              wr_data,
	output logic                              commit_valid,
	output lane_pkg::reg_index_t              commit_dst,
	output lane_pkg::lane_data_t              commit_data
);

	localparam int SHAMT_W = $clog2(`LANE_DATA_WIDTH);

	typedef enum logic [1:0] {IDLE, READ_FIRST, READ_SECOND, EXECUTE} exec_state_e;

	exec_state_e          state;
	lane_pkg::lane_op_e   cur_op;
	lane_pkg::read_plan_e cur_plan;
	lane_pkg::reg_index_t cur_dst;
	lane_pkg::reg_index_t cur_src1;
	lane_pkg::reg_index_t cur_src2;
	lane_pkg::lane_data_t cur_scalar;
	lane_pkg::lane_data_t operand_hold;
	lane_pkg::lane_data_t operand_a;
	lane_pkg::lane_data_t operand_b;
	lane_pkg::lane_data_t alu_result;
	lane_pkg::bank_row_t  row1;
	lane_pkg::bank_row_t  row2;

	// Free to take a command when idle or committing
	assign q_pop = q_valid && ((state == IDLE) || (state == EXECUTE));

	////////////////////////////////////////////////////////////
	// Sequencer
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				READ_FIRST:  state <= (cur_plan == lane_pkg::PLAN_SERIAL) ? READ_SECOND : EXECUTE;
				READ_SECOND: state <= EXECUTE;
				default: begin
					if (!q_pop) begin
						state <= IDLE;
					end else if (q_plan == lane_pkg::PLAN_NONE) begin
						state <= EXECUTE;
					end else begin
						state <= READ_FIRST;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (q_pop) begin
			cur_op     <= q_op;
			cur_plan   <= q_plan;
			cur_dst    <= q_dst;
			cur_src1   <= q_src1;
			cur_src2   <= q_src2;
			cur_scalar <= q_scalar;
		end
		// Source 1 data lands while the second read is issued
		if (state == READ_SECOND) begin
			operand_hold <= cur_src1[0] ? odd_rd_data : even_rd_data;
		end
	end

	////////////////////////////////////////////////////////////
	// Bank read steering
	assign row1 = cur_src1[`LANE_REG_INDEX_WIDTH-1:1];
	assign row2 = cur_src2[`LANE_REG_INDEX_WIDTH-1:1];

	always_comb begin
		odd_rd_en   = 1'b0;
		even_rd_en  = 1'b0;
		odd_rd_row  = row1;
		even_rd_row = row1;
		if (state == READ_FIRST) begin
			odd_rd_en  = cur_src1[0];
			even_rd_en = !cur_src1[0];
			// Parallel plan reads source 2 from the other bank, or the same row
			if (cur_plan == lane_pkg::PLAN_PARALLEL) begin
				if (cur_src2[0]) begin
					odd_rd_en  = 1'b1;
					odd_rd_row = row2;
				end else begin
					even_rd_en  = 1'b1;
					even_rd_row = row2;
				end
			end
		end else if (state == READ_SECOND) begin
			odd_rd_en   = cur_src2[0];
			even_rd_en  = !cur_src2[0];
			odd_rd_row  = row2;
			even_rd_row = row2;
		end
	end

	////////////////////////////////////////////////////////////
	// ALU and write-back
	assign operand_a = (cur_plan == lane_pkg::PLAN_SERIAL) ? operand_hold :
		(cur_src1[0] ? odd_rd_data : even_rd_data);
	assign operand_b = cur_src2[0] ? odd_rd_data : even_rd_data;

	always_comb begin
		case (cur_op)
			lane_pkg::OP_ADD: alu_result = operand_a + operand_b;
			lane_pkg::OP_SUB: alu_result = operand_a - operand_b;
			lane_pkg::OP_AND: alu_result = operand_a & operand_b;
			lane_pkg::OP_OR:  alu_result = operand_a | operand_b;
			lane_pkg::OP_XOR: alu_result = operand_a ^ operand_b;
			lane_pkg::OP_SLL: alu_result = operand_a << operand_b[SHAMT_W-1:0];
			lane_pkg::OP_SRL: alu_result = operand_a >> operand_b[SHAMT_W-1:0];
			default:          alu_result = cur_scalar;
		endcase
	end

	assign commit_valid = (state == EXECUTE);
	assign commit_dst   = cur_dst;
	assign commit_data  = alu_result;
	assign odd_wr_en    = commit_valid && cur_dst[0];
	assign even_wr_en   = commit_valid && !cur_dst[0];
	assign wr_row       = cur_dst[`LANE_REG_INDEX_WIDTH-1:1];
	assign wr_data      = alu_result;

endmodule

`default_nettype wire

// File: lane_issue_decode.sv
/*
 Command capture stage, one cycle of latency.
 The read plan is fixed here so execute only follows it.
*/
`default_nettype none

`include "lane_config.svh"

module lane_issue_decode (
	input  wire logic                       clock,
	input  wire logic                       reset,
	input  wire logic                       cmd_valid,
	input  wire logic [`LANE_OP_WIDTH-1:0]  cmd_op,
	input  wire lane_pkg::reg_index_t       cmd_dst,
	input  wire lane_pkg::reg_index_t       cmd_src1,
	input  wire lane_pkg::reg_index_t       cmd_src2,
	input  wire lane_pkg::lane_data_t       cmd_scalar,
	output lane_pkg::lane_op_e              dec_op,
	output lane_pkg::read_plan_e            dec_plan,
	output logic                            dec_valid,
	output lane_pkg::reg_index_t            dec_dst,
	output lane_pkg::reg_index_t            dec_src1,
	output lane_pkg::reg_index_t            dec_src2,
	output lane_pkg::lane_data_t            dec_scalar
);

	lane_pkg::lane_op_e   op;
	lane_pkg::read_plan_e plan;

	assign op = lane_pkg::lane_op_e'(cmd_op);

	// Two different rows in one bank need a second read cycle
	always_comb begin
		if (op == lane_pkg::OP_LDS) begin
			plan = lane_pkg::PLAN_NONE;
		end else if ((cmd_src1[0] != cmd_src2[0]) || (cmd_src1[`LANE_REG_INDEX_WIDTH-1:1] ==
				cmd_src2[`LANE_REG_INDEX_WIDTH-1:1])) begin
			plan = lane_pkg::PLAN_PARALLEL;
		end else begin
			plan = lane_pkg::PLAN_SERIAL;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= cmd_valid;
		end
	end

	// Command fields
	always_ff @(posedge clock) begin
		dec_op     <= op;
		dec_plan   <= plan;
		dec_dst    <= cmd_dst;
		dec_src1   <= cmd_src1;
		dec_src2   <= cmd_src2;
		dec_scalar <= cmd_scalar;
	end

endmodule

`default_nettype wire

// File: lane_pkg.sv
/*
 Types for the lane command path.
 Register index bit 0 selects the bank (1 = odd), upper bits are the row.
*/
`default_nettype none

`include "lane_config.svh"

package lane_pkg;

	typedef logic [`LANE_DATA_WIDTH-1:0] lane_data_t;
	typedef logic [`LANE_REG_INDEX_WIDTH-1:0] reg_index_t;
	typedef logic [`LANE_ROW_WIDTH-1:0] bank_row_t;

	// Opcodes as sent by the scalar unit
	typedef enum logic [`LANE_OP_WIDTH-1:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_AND = 3'd2,
		OP_OR  = 3'd3,
		OP_XOR = 3'd4,
		OP_SLL = 3'd5,
		OP_SRL = 3'd6,
		OP_LDS = 3'd7
	} lane_op_e;

	// How execute reads the two sources
	typedef enum logic [1:0] {
		PLAN_NONE     = 2'd0,
		PLAN_PARALLEL = 2'd1,
		PLAN_SERIAL   = 2'd2
	} read_plan_e;

endpackage

`default_nettype wire

// File: lane_register_bank.sv
/*
 One half of the lane register file, cleared by reset.
 Read data is registered, one cycle after rd_en.
 A read of the row being written returns the new data.
*/
`default_nettype none

`include "lane_config.svh"

module lane_register_bank (
	input  wire logic                         clock,
	input  wire logic                         reset,
	input  wire logic                         rd_en,
	input  wire logic [`LANE_ROW_WIDTH-1:0]   rd_row,
	output logic [`LANE_DATA_WIDTH-1:0]       rd_data,
	input  wire logic                         wr_en,
	input  wire logic [`LANE_ROW_WIDTH-1:0]   wr_row,
	input  wire logic [`LANE_DATA_WIDTH-1:0]  wr_data
);

	localparam int ROWS = `LANE_NUM_REGS / 2;

	logic [`LANE_DATA_WIDTH-1:0] mem [ROWS];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < ROWS; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_en) begin
			mem[wr_row] <= wr_data;
		end
	end

	// Write-first forwarding on a row collision
	always_ff @(posedge clock) begin
		if (rd_en) begin
			rd_data <= (wr_en && (wr_row == rd_row)) ? wr_data : mem[rd_row];
		end
	end

endmodule

`default_nettype wire

// File: lane_unit.sv
/*
 One SIMD lane, command path only.
 Sender starts with LANE_QUEUE_DEPTH credits, one per cmd_valid cycle.
 Commits come in command order and cannot be stalled.
*/
`default_nettype none

`include "lane_config.svh"

module lane_unit (
	input  wire logic                         clock,
	input  wire logic                         reset,
	input  wire logic                         cmd_valid,
	input  wire logic [`LANE_OP_WIDTH-1:0]    cmd_op,
	input  wire lane_pkg::reg_index_t         cmd_dst,
	input  wire lane_pkg::reg_index_t         cmd_src1,
	input  wire lane_pkg::reg_index_t         cmd_src2,
	input  wire lane_pkg::lane_data_t         cmd_scalar,
	output logic                              credit_return,
	output logic                              commit_valid,
	output lane_pkg::reg_index_t              commit_dst,
	output lane_pkg::lane_data_t              commit_data
);

	// Decode to queue
	logic                 dec_valid;
	lane_pkg::lane_op_e   dec_op;
	lane_pkg::read_plan_e dec_plan;
	lane_pkg::reg_index_t dec_dst;
	lane_pkg::reg_index_t dec_src1;
	lane_pkg::reg_index_t dec_src2;
	lane_pkg::lane_data_t dec_scalar;

	// Queue to execute
	logic                 q_valid;
	logic                 q_pop;
	lane_pkg::lane_op_e   q_op;
	lane_pkg::read_plan_e q_plan;
	lane_pkg::reg_index_t q_dst;
	lane_pkg::reg_index_t q_src1;
	lane_pkg::reg_index_t q_src2;
	lane_pkg::lane_data_t q_scalar;

	// Register banks
	logic                 odd_rd_en;
	logic                 even_rd_en;
	lane_pkg::bank_row_t  odd_rd_row;
	lane_pkg::bank_row_t  even_rd_row;
	lane_pkg::lane_data_t odd_rd_data;
	lane_pkg::lane_data_t even_rd_data;
	logic                 odd_wr_en;
	logic                 even_wr_en;
	lane_pkg::bank_row_t  wr_row;
	lane_pkg::lane_data_t wr_data;

	lane_issue_decode u_decode (
		.clock(clock), .reset(reset),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_dst(cmd_dst),
		.cmd_src1(cmd_src1), .cmd_src2(cmd_src2), .cmd_scalar(cmd_scalar),
		.dec_valid(dec_valid), .dec_op(dec_op), .dec_plan(dec_plan), .dec_dst(dec_dst),
		.dec_src1(dec_src1), .dec_src2(dec_src2), .dec_scalar(dec_scalar)
	);

	lane_command_queue u_queue (
		.clock(clock), .reset(reset),
		.dec_valid(dec_valid), .dec_op(dec_op), .dec_plan(dec_plan), .dec_dst(dec_dst),
		.dec_src1(dec_src1), .dec_src2(dec_src2), .dec_scalar(dec_scalar),
		.q_pop(q_pop), .q_valid(q_valid), .q_op(q_op), .q_plan(q_plan), .q_dst(q_dst),
		.q_src1(q_src1), .q_src2(q_src2), .q_scalar(q_scalar),
		.credit_return(credit_return)
	);

	lane_register_bank bank_odd (
		.clock(clock), .reset(reset),
		.rd_en(odd_rd_en), .rd_row(odd_rd_row), .rd_data(odd_rd_data),
		.wr_en(odd_wr_en), .wr_row(wr_row), .wr_data(wr_data)
	);

	lane_register_bank bank_even (
		.clock(clock), .reset(reset),
		.rd_en(even_rd_en), .rd_row(even_rd_row), .rd_data(even_rd_data),
		.wr_en(even_wr_en), .wr_row(wr_row), .wr_data(wr_data)
	);

	lane_execute u_execute (
		.clock(clock), .reset(reset),
		.q_valid(q_valid), .q_op(q_op), .q_plan(q_plan), .q_dst(q_dst),
		.q_src1(q_src1), .q_src2(q_src2), .q_scalar(q_scalar), .q_pop(q_pop),
		.odd_rd_en(odd_rd_en), .odd_rd_row(odd_rd_row),
		.even_rd_en(even_rd_en), .even_rd_row(even_rd_row),
		.odd_rd_data(odd_rd_data), .even_rd_data(even_rd_data),
		.odd_wr_en(odd_wr_en), .even_wr_en(even_wr_en), .wr_row(wr_row), .wr_data(wr_data),
		.commit_valid(commit_valid), .commit_dst(commit_dst), .commit_data(commit_data)
	);

endmodule

`default_nettype wire

// File: lane_unit_sva.sv
/*
 Command queue assertions, bound into every lane_command_queue.
 Uses the queue's internal count as its occupancy.
 The testbench top reads failures at the end of the run.
*/
`default_nettype none

`include "lane_config.svh"

module lane_unit_sva #(
	parameter int CNT_W = $clog2(`LANE_QUEUE_DEPTH + 1)
) (
	input wire logic             clock,
	input wire logic             reset,
	input wire logic             dec_valid,
	input wire logic             q_pop,
	input wire logic             credit_return,
	input wire logic [CNT_W-1:0] count
);

	timeunit 1ns;
	timeprecision 1ps;

	int failures = 0;

	// Credits must keep pushes off a full queue
	push_not_full: assert property (@(posedge clock) disable iff (reset)
		dec_valid |-> (count < CNT_W'(`LANE_QUEUE_DEPTH)))
	else begin
		failures++;
		$error("push into a full command queue");
	end

	pop_not_empty: assert property (@(posedge clock) disable iff (reset)
		q_pop |-> (count != '0))
	else begin
		failures++;
		$error("pop from an empty command queue");
	end

	// Queue empty and no credit in the cycle after reset
	quiet_after_reset: assert property (@(posedge clock)
		reset |=> (!credit_return && (count == '0)))
	else begin
		failures++;
		$error("credit_return or occupancy not clear after reset");
	end

endmodule

bind lane_command_queue lane_unit_sva u_sva (
	.clock(clock),
	.reset(reset),
	.dec_valid(dec_valid),
	.q_pop(q_pop),
	.credit_return(credit_return),
	.count(count)
);

`default_nettype wire

// File: tb_lane_unit.sv
/*
 Testbench top for lane_unit: clock, reset, credit-limited random commands.
 Five tests of CMDS_PER_TEST commands, each followed by a full drain.
 Comparison happens in lane_checker; a watchdog bounds the run.
*/
`default_nettype none

`include "lane_config.svh"

module tb_lane_unit;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLOCK_PERIOD = 20;
	localparam int CMDS_PER_TEST = 32;
	localparam int NUM_TESTS = 5;
	localparam int WORST_CYCLES_PER_CMD = 10;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * CMDS_PER_TEST * WORST_CYCLES_PER_CMD + 100;

	logic                      clock;
	logic                      reset;
	logic                      cmd_valid;
	logic [`LANE_OP_WIDTH-1:0] cmd_op;
	lane_pkg::reg_index_t      cmd_dst;
	lane_pkg::reg_index_t      cmd_src1;
	lane_pkg::reg_index_t      cmd_src2;
	lane_pkg::lane_data_t      cmd_scalar;
	logic                      credit_return;
	logic                      commit_valid;
	lane_pkg::reg_index_t      commit_dst;
	lane_pkg::lane_data_t      commit_data;
	logic                      end_of_test;
	int                        credits;
	int                        error_count;
	int                        commit_count;
	int                        pending;
	integer                    seed;
	int                        tests_run;
	int                        prev_errors;
	int                        prev_commits;
	int                        total_errors;

	lane_unit UUT (
		.clock(clock), .reset(reset),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_dst(cmd_dst),
		.cmd_src1(cmd_src1), .cmd_src2(cmd_src2), .cmd_scalar(cmd_scalar),
		.credit_return(credit_return),
		.commit_valid(commit_valid), .commit_dst(commit_dst), .commit_data(commit_data)
	);

	lane_checker u_checker (
		.clock(clock), .reset(reset),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_dst(cmd_dst),
		.cmd_src1(cmd_src1), .cmd_src2(cmd_src2), .cmd_scalar(cmd_scalar),
		.credit_return(credit_return),
		.commit_valid(commit_valid), .commit_dst(commit_dst), .commit_data(commit_data),
		.end_of_test(end_of_test), .sender_credits(credits),
		.error_count(error_count), .commit_count(commit_count), .pending(pending)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	// Sender credit counter
	always @(posedge clock) begin
		if (reset) begin
			credits <= `LANE_QUEUE_DEPTH;
		end else begin
			credits <= credits - (cmd_valid ? 1 : 0) + (credit_return ? 1 : 0);
		end
	end

	function automatic lane_pkg::reg_index_t pick_register();
		return 5'($random(seed));
	endfunction

	function automatic lane_pkg::lane_data_t random_word();
		return $random(seed);
	endfunction

	// LDS only when asked for
	function automatic logic [`LANE_OP_WIDTH-1:0] choose_opcode(input bit with_lds);
		if (with_lds) begin
			return 3'($unsigned($random(seed)) % 8);
		end
		return 3'($unsigned($random(seed)) % 7);
	endfunction

	// Called 2 ns after an edge; returns 2 ns after the edge that took the command
	task automatic send_command(
		input logic [`LANE_OP_WIDTH-1:0] op,
		input lane_pkg::reg_index_t dst,
		input lane_pkg::reg_index_t src1,
		input lane_pkg::reg_index_t src2,
		input lane_pkg::lane_data_t scalar
	);
		while (credits == 0) begin
			@(posedge clock);
			#2;
		end
		cmd_valid  = 1'b1;
		cmd_op     = op;
		cmd_dst    = dst;
		cmd_src1   = src1;
		cmd_src2   = src2;
		cmd_scalar = scalar;
		@(posedge clock);
		#2;
		cmd_valid = 1'b0;
	endtask

	task automatic finish_test(input string name);
		while ((pending != 0) || (credits < `LANE_QUEUE_DEPTH)) begin
			@(posedge clock);
			#2;
		end
		end_of_test = 1'b1;
		@(posedge clock);
		#2;
		end_of_test = 1'b0;
		tests_run++;
		$display("Test %0d %s: %0d commits, %0d errors", tests_run, name,
			commit_count - prev_commits, error_count - prev_errors);
		prev_commits = commit_count;
		prev_errors  = error_count;
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	task automatic load_all_registers();
		for (int r = 0; r < `LANE_NUM_REGS; r++) begin
			send_command(lane_pkg::OP_LDS, 5'(r), pick_register(), pick_register(),
				random_word());
		end
	endtask

	task automatic alu_sweep();
		repeat (CMDS_PER_TEST) begin
			send_command(choose_opcode(1'b0), pick_register(), pick_register(),
				pick_register(), random_word());
		end
	endtask

	// Each command reads the result of the one before
	task automatic dependent_chain();
		lane_pkg::reg_index_t prev;
		lane_pkg::reg_index_t next;
		prev = pick_register();
		repeat (CMDS_PER_TEST) begin
			next = pick_register();
			send_command(choose_opcode(1'b0), next, prev, pick_register(), random_word());
			prev = next;
		end
	endtask

	task automatic same_bank_sources();
		lane_pkg::reg_index_t src1;
		lane_pkg::reg_index_t src2;
		repeat (CMDS_PER_TEST) begin
			src1    = pick_register();
			src2    = pick_register();
			src2[0] = src1[0];
			if (($random(seed) & 3) == 0) begin
				src2 = src1;
			end
			send_command(choose_opcode(1'b0), pick_register(), src1, src2, random_word());
		end
	endtask

	task automatic mixed_traffic();
		repeat (CMDS_PER_TEST) begin
			send_command(choose_opcode(1'b1), pick_register(), pick_register(),
				pick_register(), random_word());
			repeat ($unsigned($random(seed)) % 3) begin
				@(posedge clock);
				#2;
			end
		end
	endtask

	initial begin
		seed         = 32'hc8e9a309;
		tests_run    = 0;
		prev_errors  = 0;
		prev_commits = 0;
		reset        = 1'b1;
		cmd_valid    = 1'b0;
		cmd_op       = '0;
		cmd_dst      = '0;
		cmd_src1     = '0;
		cmd_src2     = '0;
		cmd_scalar   = '0;
		end_of_test  = 1'b0;
		repeat (3) @(posedge clock);
		#2;
		reset = 1'b0;
		// Idle period, the checker flags any commit or credit here
		repeat (10) @(posedge clock);
		#2;
		load_all_registers();
		finish_test("scalar loads");
		alu_sweep();
		finish_test("alu opcodes");
		dependent_chain();
		finish_test("dependent chain");
		same_bank_sources();
		finish_test("same bank sources");
		mixed_traffic();
		finish_test("mixed traffic");
		total_errors = error_count + UUT.u_queue.u_sva.failures;
		$display("Summary: %0d tests, %0d commits, %0d errors, %0d assertion failures",
			tests_run, commit_count, error_count, UUT.u_queue.u_sva.failures);
		if (total_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_CYCLES * CLOCK_PERIOD);
		$display("Timeout: commands did not drain within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
